//--- ecc_mem.f
+incdir+rtl
rtl/ecc_mem_pkg.sv
rtl/secded_codec.sv
rtl/tp_sram.sv
rtl/ecc_ram_bank.sv
rtl/bank_select.sv
rtl/read_collect.sv
rtl/ecc_mem_top.sv
sim/ecc_mem_checker.sv
sim/ecc_mem_tb.sv

//--- rtl/bank_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_macros.svh"

module bank_select (
    input  wire logic                         wr_cs,
    input  wire logic                         wr_we,
    input  wire logic [`ECC_MEM_ADDR_W-1:0]   wr_addr,
    input  wire logic                         rd_cs,
    input  wire logic                         rd_re,
    input  wire logic [`ECC_MEM_ADDR_W-1:0]   rd_addr,
    output logic      [`ECC_MEM_NUM_BANKS-1:0] bank_wr_en,
    output logic      [`ECC_MEM_NUM_BANKS-1:0] bank_rd_en,
    output logic      [`ECC_MEM_ROW_W-1:0]    wr_row,
    output logic      [`ECC_MEM_ROW_W-1:0]    rd_row
);

    localparam int BANK_W = `ECC_MEM_BANK_W;

    logic [BANK_W-1:0] wr_bank;
    logic [BANK_W-1:0] rd_bank;

    // Bank field sits above the row.
    assign wr_bank = wr_addr[`ECC_MEM_ADDR_W-1 -: BANK_W];
    assign rd_bank = rd_addr[`ECC_MEM_ADDR_W-1 -: BANK_W];
    assign wr_row  = wr_addr[`ECC_MEM_ROW_W-1:0];
    assign rd_row  = rd_addr[`ECC_MEM_ROW_W-1:0];

    always_comb begin
        for (int b = 0; b < `ECC_MEM_NUM_BANKS; b++) begin
            bank_wr_en[b] = wr_cs & wr_we & (wr_bank == BANK_W'(b));
            bank_rd_en[b] = rd_cs & rd_re & (rd_bank == BANK_W'(b));
        end
    end

    // Every address of an active port lands in exactly one bank.
    always_comb begin
        a_en_onehot: assert ($onehot0(bank_wr_en) && $onehot0(bank_rd_en) &&
                             ((|bank_wr_en) == (wr_cs && wr_we)) &&
                             ((|bank_rd_en) == (rd_cs && rd_re)))
            else $error("bank enable vector not one-hot for an active port");
    end

endmodule

`default_nettype wire

//--- rtl/ecc_mem_macros.svh
`ifndef ECC_MEM_MACROS_SVH
`define ECC_MEM_MACROS_SVH

// Word address, bank field on top of the row field.
`define ECC_MEM_ADDR_W 10
`define ECC_MEM_BANK_W 2
`define ECC_MEM_ROW_W 8

// Stored word: data plus SEC-DED check bits.
`define ECC_MEM_DATA_W 64
`define ECC_MEM_CHK_W 8
`define ECC_MEM_CW_W 72

`define ECC_MEM_NUM_BANKS 4

`endif

//--- rtl/ecc_mem_pkg.sv
`default_nettype none

package ecc_mem_pkg;

    // Read status reported with every returned word.
    typedef enum logic [1:0] {
        ECC_OK            = 2'b00,
        ECC_CORRECTED     = 2'b01,
        ECC_UNCORRECTABLE = 2'b10,
        ECC_BYPASSED      = 2'b11
    } ecc_status_e;

endpackage

`default_nettype wire

//--- rtl/ecc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_macros.svh"

module ecc_mem_top (
    input  wire logic                       w_clk,
    input  wire logic                       r_clk,
    input  wire logic                       rst_n,
    input  wire logic                       wr_cs,
    input  wire logic                       wr_we,
    input  wire logic [`ECC_MEM_ADDR_W-1:0] wr_addr,
    input  wire logic [`ECC_MEM_DATA_W-1:0] wr_data,
    input  wire logic                       inj_single,
    input  wire logic                       inj_double,
    input  wire logic                       rd_cs,
    input  wire logic                       rd_re,
    input  wire logic [`ECC_MEM_ADDR_W-1:0] rd_addr,
    input  wire logic                       ecc_bypass,
    output logic      [`ECC_MEM_DATA_W-1:0] rd_data,
    output ecc_mem_pkg::ecc_status_e        rd_status,
    output logic                            rd_valid
);
    import ecc_mem_pkg::*;

    logic [`ECC_MEM_NUM_BANKS-1:0] bank_wr_en;
    logic [`ECC_MEM_NUM_BANKS-1:0] bank_rd_en;
    logic [`ECC_MEM_ROW_W-1:0]     wr_row;
    logic [`ECC_MEM_ROW_W-1:0]     rd_row;
    logic [`ECC_MEM_DATA_W-1:0]    bank_data   [`ECC_MEM_NUM_BANKS];
    ecc_status_e                   bank_status [`ECC_MEM_NUM_BANKS];
    logic [`ECC_MEM_NUM_BANKS-1:0] bank_valid;

    bank_select u_bank_select (
        .wr_cs      (wr_cs),
        .wr_we      (wr_we),
        .wr_addr    (wr_addr),
        .rd_cs      (rd_cs),
        .rd_re      (rd_re),
        .rd_addr    (rd_addr),
        .bank_wr_en (bank_wr_en),
        .bank_rd_en (bank_rd_en),
        .wr_row     (wr_row),
        .rd_row     (rd_row)
    );

    for (genvar b = 0; b < `ECC_MEM_NUM_BANKS; b++) begin : g_bank
        ecc_ram_bank u_bank (
            .w_clk          (w_clk),
            .r_clk          (r_clk),
            .rst_n          (rst_n),
            .wr_cs          (bank_wr_en[b]),
            .wr_we          (wr_we),
            .wr_row         (wr_row),
            .wr_data        (wr_data),
            .inj_single     (inj_single),
            .inj_double     (inj_double),
            .rd_cs          (bank_rd_en[b]),
            .rd_re          (rd_re),
            .rd_row         (rd_row),
            .ecc_bypass     (ecc_bypass),
            .bank_rd_data   (bank_data[b]),
            .bank_rd_status (bank_status[b]),
            .bank_rd_valid  (bank_valid[b])
        );
    end

    read_collect u_read_collect (
        .r_clk          (r_clk),
        .rst_n          (rst_n),
        .bank_rd_data   (bank_data),
        .bank_rd_status (bank_status),
        .bank_rd_valid  (bank_valid),
        .rd_data        (rd_data),
        .rd_status      (rd_status),
        .rd_valid       (rd_valid)
    );

endmodule

`default_nettype wire

//--- rtl/ecc_ram_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_macros.svh"

module ecc_ram_bank (
    input  wire logic                       w_clk,
    input  wire logic                       r_clk,
    input  wire logic                       rst_n,
    input  wire logic                       wr_cs,
    input  wire logic                       wr_we,
    input  wire logic [`ECC_MEM_ROW_W-1:0]  wr_row,
    input  wire logic [`ECC_MEM_DATA_W-1:0] wr_data,
    input  wire logic                       inj_single,
    input  wire logic                       inj_double,
    input  wire logic                       rd_cs,
    input  wire logic                       rd_re,
    input  wire logic [`ECC_MEM_ROW_W-1:0]  rd_row,
    input  wire logic                       ecc_bypass,
    output logic      [`ECC_MEM_DATA_W-1:0] bank_rd_data,
    output ecc_mem_pkg::ecc_status_e        bank_rd_status,
    output logic                            bank_rd_valid
);
    import ecc_mem_pkg::*;

    logic                       wr_en;
    logic                       rd_en;
    logic                       collision;
    logic                       rd_chk;
    logic [`ECC_MEM_CHK_W-1:0]  wr_chk;
    logic [`ECC_MEM_DATA_W-1:0] inj_mask;
    logic [`ECC_MEM_CW_W-1:0]   wr_cw;
    logic [`ECC_MEM_CW_W-1:0]   rd_cw;
    logic                       rd_en_d1;
    logic                       rd_chk_d1;
    logic                       bypass_d1;
    logic [`ECC_MEM_DATA_W-1:0] dec_data;
    ecc_status_e                dec_status;

    assign wr_en = wr_cs & wr_we;
    assign rd_en = rd_cs & rd_re;

    // Read of a row being written this cycle gets no error report.
    assign collision = wr_en & (wr_row == rd_row);
    assign rd_chk    = rd_en & ~collision;

    // Injected flips go in after encoding.
    assign inj_mask = {{(`ECC_MEM_DATA_W-2){1'b0}}, inj_double, inj_single | inj_double};
    assign wr_cw    = {wr_chk, wr_data ^ inj_mask};

    secded_codec u_secded_codec (
        .enc_data   (wr_data),
        .enc_chk    (wr_chk),
        .dec_cw     (rd_cw),
        .bypass     (bypass_d1),
        .dec_data   (dec_data),
        .dec_status (dec_status)
    );

    tp_sram u_tp_sram (
        .w_clk  (w_clk),
        .r_clk  (r_clk),
        .wr_en  (wr_en),
        .wr_row (wr_row),
        .wr_cw  (wr_cw),
        .rd_en  (rd_en),
        .rd_row (rd_row),
        .rd_cw  (rd_cw)
    );

    // Line up with the SRAM output register.
    always_ff @(posedge r_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_en_d1  <= 1'b0;
            rd_chk_d1 <= 1'b0;
            bypass_d1 <= 1'b0;
        end else begin
            rd_en_d1  <= rd_en;
            rd_chk_d1 <= rd_chk;
            bypass_d1 <= ecc_bypass;
        end
    end

    always_ff @(posedge r_clk or negedge rst_n) begin
        if (!rst_n) begin
            bank_rd_valid  <= 1'b0;
            bank_rd_status <= ECC_OK;
        end else begin
            bank_rd_valid  <= rd_en_d1;
            bank_rd_status <= rd_chk_d1 ? dec_status : ECC_OK;
        end
    end

    always_ff @(posedge r_clk) begin
        if (rd_en_d1) begin
            bank_rd_data <= dec_data;
        end
    end

    a_inj_excl: assert property (@(posedge w_clk) disable iff (!rst_n)
        wr_en |-> !(inj_single && inj_double))
        else $error("single and double injection requested together");

endmodule

`default_nettype wire

//--- rtl/read_collect.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_macros.svh"

module read_collect (
    input  wire logic                          r_clk,
    input  wire logic                          rst_n,
    input  wire logic [`ECC_MEM_DATA_W-1:0]    bank_rd_data   [`ECC_MEM_NUM_BANKS],
    input  var  ecc_mem_pkg::ecc_status_e      bank_rd_status [`ECC_MEM_NUM_BANKS],
    input  wire logic [`ECC_MEM_NUM_BANKS-1:0] bank_rd_valid,
    output logic      [`ECC_MEM_DATA_W-1:0]    rd_data,
    output ecc_mem_pkg::ecc_status_e           rd_status,
    output logic                               rd_valid
);
    import ecc_mem_pkg::*;

    logic [`ECC_MEM_DATA_W-1:0] data_or;
    logic [1:0]                 stat_or;
    logic                       any_valid;

    // Only the bank that was read drives the merged bus.
    always_comb begin
        data_or = '0;
        stat_or = '0;
        for (int b = 0; b < `ECC_MEM_NUM_BANKS; b++) begin
            if (bank_rd_valid[b]) begin
                data_or |= bank_rd_data[b];
                stat_or |= bank_rd_status[b];
            end
        end
    end

    assign any_valid = |bank_rd_valid;

    always_ff @(posedge r_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid  <= 1'b0;
            rd_status <= ECC_OK;
        end else begin
            rd_valid  <= any_valid;
            rd_status <= ecc_status_e'(stat_or);
        end
    end

    always_ff @(posedge r_clk) begin
        if (any_valid) begin
            rd_data <= data_or;
        end
    end

    a_one_bank: assert property (@(posedge r_clk) disable iff (!rst_n)
        $onehot0(bank_rd_valid))
        else $error("more than one bank returned data in a cycle");

endmodule

`default_nettype wire

//--- rtl/secded_codec.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_macros.svh"

module secded_codec (
    input  wire logic [`ECC_MEM_DATA_W-1:0] enc_data,
    output logic      [`ECC_MEM_CHK_W-1:0]  enc_chk,
    input  wire logic [`ECC_MEM_CW_W-1:0]   dec_cw,
    input  wire logic                       bypass,
    output logic      [`ECC_MEM_DATA_W-1:0] dec_data,
    output ecc_mem_pkg::ecc_status_e        dec_status
);
    import ecc_mem_pkg::*;

    localparam int DATA_W = `ECC_MEM_DATA_W;
    localparam int HAM_W  = `ECC_MEM_CHK_W - 1;

    logic [HAM_W-1:0]  enc_ham;
    logic [HAM_W-1:0]  syn_ham;
    logic              par_err;
    logic [HAM_W:0]    syndrome;
    logic [DATA_W-1:0] flip;

    // Hamming position of data bit idx; powers of two hold the check bits.
    function automatic logic [HAM_W-1:0] data_pos(input int idx);
        int               cnt;
        logic [HAM_W-1:0] res;
        cnt = 0;
        res = '0;
        for (int p = 1; p < `ECC_MEM_CW_W; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (cnt == idx) begin
                    res = p[HAM_W-1:0];
                end
                cnt++;
            end
        end
        return res;
    endfunction

    always_comb begin
        enc_ham = '0;
        for (int i = 0; i < DATA_W; i++) begin
            enc_ham ^= {HAM_W{enc_data[i]}} & data_pos(i);
        end
    end

    // Top bit makes the whole codeword even parity.
    assign enc_chk = {(^enc_data) ^ (^enc_ham), enc_ham};

    always_comb begin
        syn_ham = dec_cw[DATA_W +: HAM_W];
        for (int i = 0; i < DATA_W; i++) begin
            syn_ham ^= {HAM_W{dec_cw[i]}} & data_pos(i);
        end
    end

    assign par_err  = ^dec_cw;
    assign syndrome = {par_err, syn_ham};

    always_comb begin
        for (int i = 0; i < DATA_W; i++) begin
            flip[i] = par_err && (syn_ham == data_pos(i));
        end
    end

    always_comb begin
        if (bypass) begin
            dec_data   = dec_cw[DATA_W-1:0];
            dec_status = ECC_BYPASSED;
        end else begin
            dec_data = dec_cw[DATA_W-1:0] ^ flip;
            if (syndrome == '0) begin
                dec_status = ECC_OK;
            end else if (par_err && (int'(syn_ham) < `ECC_MEM_CW_W)) begin
                // Odd parity, syndrome inside the codeword.
                dec_status = ECC_CORRECTED;
            end else begin
                dec_status = ECC_UNCORRECTABLE;
            end
        end
    end

    // A correction needs a nonzero syndrome and repairs exactly one data bit,
    // unless the syndrome points at a check bit.
    always_comb begin
        a_corr_one_bit: assert (dec_status != ECC_CORRECTED ||
                                (syndrome != '0 &&
                                 ($countones(dec_data ^ dec_cw[DATA_W-1:0]) == 1 ||
                                  $onehot0(syn_ham))))
            else $error("corrected word without a valid single-bit syndrome");
    end

endmodule

`default_nettype wire

//--- rtl/tp_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "ecc_mem_macros.svh"

module tp_sram (
    input  wire logic                      w_clk,
    input  wire logic                      r_clk,
    input  wire logic                      wr_en,
    input  wire logic [`ECC_MEM_ROW_W-1:0] wr_row,
    input  wire logic [`ECC_MEM_CW_W-1:0]  wr_cw,
    input  wire logic                      rd_en,
    input  wire logic [`ECC_MEM_ROW_W-1:0] rd_row,
    output logic      [`ECC_MEM_CW_W-1:0]  rd_cw
);

    localparam int DEPTH = 1 << `ECC_MEM_ROW_W;

    logic [`ECC_MEM_CW_W-1:0] mem [DEPTH];

    always_ff @(posedge w_clk) begin
        if (wr_en) begin
            mem[wr_row] <= wr_cw;
        end
    end

    // Same-edge write to rd_row is not seen; old word comes out.
    always_ff @(posedge r_clk) begin
        if (rd_en) begin
            rd_cw <= mem[rd_row];
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ECC memory testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ecc_mem.f --top-module ecc_mem_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vecc_mem_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

//--- sim/ecc_mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_checker (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        rd_valid,
    input  wire logic [63:0] rd_data,
    input  var  ecc_mem_pkg::ecc_status_e rd_status
);
    import ecc_mem_pkg::*;

    logic [63:0] exp_data_q [$];
    ecc_status_e exp_stat_q [$];
    int          exp_id_q   [$];
    int          outstanding [int];
    bit          test_bad    [int];
    int          errors       = 0;
    int          checks       = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [63:0] exp_data;
    ecc_status_e exp_stat;
    int          exp_id;

    task automatic push_expect(input logic [63:0] data, input ecc_status_e stat, input int id);
        exp_data_q.push_back(data);
        exp_stat_q.push_back(stat);
        exp_id_q.push_back(id);
        if (outstanding.exists(id)) begin
            outstanding[id]++;
        end else begin
            outstanding[id] = 1;
            test_bad[id]    = 1'b0;
        end
    endtask

    // Outputs are registered on the rising edge; look at them mid-cycle.
    always @(negedge clk) begin
        if (rst_n && rd_valid) begin
            if (exp_data_q.size() == 0) begin
                $display("Read data returned at %0t with no read outstanding", $time);
                errors++;
            end else begin
                exp_data = exp_data_q.pop_front();
                exp_stat = exp_stat_q.pop_front();
                exp_id   = exp_id_q.pop_front();
                checks++;
                // Only the status is defined for an uncorrectable word.
                if (rd_status !== exp_stat ||
                    (exp_stat != ECC_UNCORRECTABLE && rd_data !== exp_data)) begin
                    $display("FAILED %0t: test %0d got %h %s, expected %h %s", $time, exp_id,
                             rd_data, rd_status.name(), exp_data, exp_stat.name());
                    errors++;
                    test_bad[exp_id] = 1'b1;
                end
                outstanding[exp_id]--;
                if (outstanding[exp_id] == 0) begin
                    if (test_bad[exp_id]) begin
                        tests_failed++;
                        $display("test %0d: failed", exp_id);
                    end else begin
                        tests_passed++;
                        $display("test %0d: passed", exp_id);
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/ecc_mem_stim.txt
# op(1 wr, 2 rd, 3 both, 0 idle) wr_addr wr_data inj(1 single, 2 double) rd_addr bypass
# expected_data expected_status test_id
0 000 0000000000000000 0 000 0 0000000000000000 ECC_OK 6
0 000 0000000000000000 0 000 0 0000000000000000 ECC_OK 6
1 005 1111111111111111 0 000 0 0000000000000000 ECC_OK 1
1 105 2222222222222222 0 000 0 0000000000000000 ECC_OK 1
1 2aa 3333333333333333 0 000 0 0000000000000000 ECC_OK 1
1 3ff 4444444444444444 0 000 0 0000000000000000 ECC_OK 1
2 000 0000000000000000 0 005 0 1111111111111111 ECC_OK 1
2 000 0000000000000000 0 105 0 2222222222222222 ECC_OK 1
2 000 0000000000000000 0 2aa 0 3333333333333333 ECC_OK 1
2 000 0000000000000000 0 3ff 0 4444444444444444 ECC_OK 1
1 010 0123456789abcdef 1 000 0 0000000000000000 ECC_OK 2
2 000 0000000000000000 0 010 0 0123456789abcdef ECC_CORRECTED 2
1 120 fedcba9876543210 2 000 0 0000000000000000 ECC_OK 3
2 000 0000000000000000 0 120 0 fedcba9876543210 ECC_UNCORRECTABLE 3
2 000 0000000000000000 0 010 1 0123456789abcdee ECC_BYPASSED 4
3 010 5555aaaa5555aaaa 0 010 0 0123456789abcdef ECC_OK 5
2 000 0000000000000000 0 010 0 5555aaaa5555aaaa ECC_OK 5
0 000 0000000000000000 0 000 0 0000000000000000 ECC_OK 6
2 000 0000000000000000 0 3ff 0 4444444444444444 ECC_OK 6

//--- sim/ecc_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_tb;
    import ecc_mem_pkg::*;

    logic        w_clk = 1'b0;
    logic        r_clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        wr_cs = 1'b0;
    logic        wr_we = 1'b0;
    logic [9:0]  wr_addr = '0;
    logic [63:0] wr_data = '0;
    logic        inj_single = 1'b0;
    logic        inj_double = 1'b0;
    logic        rd_cs = 1'b0;
    logic        rd_re = 1'b0;
    logic [9:0]  rd_addr = '0;
    logic        ecc_bypass = 1'b0;
    logic [63:0] rd_data;
    ecc_status_e rd_status;
    logic        rd_valid;
    int          n_lines = 0;
    bit          loaded = 1'b0;

    ecc_mem_top u_ecc_mem_top (
        .w_clk (w_clk), .r_clk (r_clk), .rst_n (rst_n),
        .wr_cs (wr_cs), .wr_we (wr_we), .wr_addr (wr_addr), .wr_data (wr_data),
        .inj_single (inj_single), .inj_double (inj_double),
        .rd_cs (rd_cs), .rd_re (rd_re), .rd_addr (rd_addr), .ecc_bypass (ecc_bypass),
        .rd_data (rd_data), .rd_status (rd_status), .rd_valid (rd_valid)
    );

    ecc_mem_checker u_checker (
        .clk (r_clk), .rst_n (rst_n), .rd_valid (rd_valid),
        .rd_data (rd_data), .rd_status (rd_status)
    );

    // Both port clocks come from one generator.
    initial begin
        forever begin
            #10;
            w_clk = ~w_clk;
            r_clk = ~r_clk;
        end
    end

    function automatic ecc_status_e status_from_name(input string name);
        if (name == "ECC_CORRECTED") return ECC_CORRECTED;
        if (name == "ECC_UNCORRECTABLE") return ECC_UNCORRECTABLE;
        if (name == "ECC_BYPASSED") return ECC_BYPASSED;
        return ECC_OK;
    endfunction

    initial begin
        int          fd;
        string       line;
        logic [3:0]  op;
        logic [9:0]  waddr;
        logic [9:0]  raddr;
        logic [63:0] wdata;
        logic [63:0] exp_data;
        logic [3:0]  inj;
        logic [3:0]  byp;
        string       stat_name;
        int          id;
        logic [3:0]  op_q    [$];
        logic [9:0]  waddr_q [$];
        logic [9:0]  raddr_q [$];
        logic [63:0] wdata_q [$];
        logic [63:0] exp_q   [$];
        logic [3:0]  inj_q   [$];
        logic [3:0]  byp_q   [$];
        string       stat_q  [$];
        int          id_q    [$];
        fd = $fopen("sim/ecc_mem_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file sim/ecc_mem_stim.txt");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 2 && line.substr(0, 0) != "#") begin
                    void'($sscanf(line, "%h %h %h %h %h %h %h %s %d", op, waddr, wdata, inj,
                                  raddr, byp, exp_data, stat_name, id));
                    op_q.push_back(op);
                    waddr_q.push_back(waddr);
                    wdata_q.push_back(wdata);
                    inj_q.push_back(inj);
                    raddr_q.push_back(raddr);
                    byp_q.push_back(byp);
                    exp_q.push_back(exp_data);
                    stat_q.push_back(stat_name);
                    id_q.push_back(id);
                end
            end
            $fclose(fd);
            n_lines = op_q.size();
            loaded  = 1'b1;
            repeat (4) @(posedge w_clk);
            rst_n <= 1'b1;
            for (int i = 0; i < n_lines; i++) begin
                @(posedge w_clk);
                wr_cs      <= op_q[i][0];
                wr_we      <= op_q[i][0];
                wr_addr    <= waddr_q[i];
                wr_data    <= wdata_q[i];
                inj_single <= op_q[i][0] && inj_q[i] == 4'd1;
                inj_double <= op_q[i][0] && inj_q[i] == 4'd2;
                rd_cs      <= op_q[i][1];
                rd_re      <= op_q[i][1];
                rd_addr    <= raddr_q[i];
                ecc_bypass <= byp_q[i][0];
                if (op_q[i][1]) begin
                    u_checker.push_expect(exp_q[i], status_from_name(stat_q[i]), id_q[i]);
                end
            end
            @(posedge w_clk);
            wr_cs <= 1'b0;
            wr_we <= 1'b0;
            rd_cs <= 1'b0;
            rd_re <= 1'b0;
            while (u_checker.exp_data_q.size() != 0) begin
                @(posedge r_clk);
            end
            // A few idle cycles to catch a stray rd_valid.
            repeat (4) @(posedge r_clk);
            $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                     u_checker.tests_passed, u_checker.tests_failed,
                     u_checker.checks, u_checker.errors);
            if (u_checker.errors == 0 && u_checker.tests_failed == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

    initial begin
        wait (loaded);
        #((n_lines + 20) * 20);
        $display("Timeout: %0d reads still had no result", u_checker.exp_data_q.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
